/* source/rtcDisplayPkg.sv */
package rtcDisplayPkg;

    ///////////////////////////////////////////////////////////////////////
    // VGA 640x480 timing, one pixel per clock
    ///////////////////////////////////////////////////////////////////////
    localparam int hActive = 640;
    localparam int hFront  = 16;
    localparam int hSync   = 96;
    localparam int hBack   = 48;
    localparam int hTotal  = 800;      // hActive + hFront + hSync + hBack

    localparam int vActive = 480;
    localparam int vFront  = 10;
    localparam int vSync   = 2;
    localparam int vBack   = 33;
    localparam int vTotal  = 525;

    // Clock chip fields: sec, min, hour, date, month, year
    localparam int fieldCount = 6;
    localparam int maxValue   = 99;    // Clamp limit, two decimal digits

    // Text row placement
    localparam int textTop    = 224;
    localparam int charWidth  = 16;
    localparam int charHeight = 32;
    localparam int textLeft   = 176;
    localparam int fieldPitch = 48;    // Two digits plus a blank cell

    ///////////////////////////////////////////////////////////////////////
    // Seven-segment glyph, index 0 is segment a ... index 6 is segment g
    ///////////////////////////////////////////////////////////////////////
    // Bounds are inclusive, rows 0..31 and columns 0..15 of a cell
    localparam logic [6:0][4:0] segRowLo = {5'd14, 5'd2, 5'd16, 5'd28, 5'd16, 5'd2, 5'd0};
    localparam logic [6:0][4:0] segRowHi = {5'd17, 5'd15, 5'd29, 5'd31, 5'd29, 5'd15, 5'd3};
    localparam logic [6:0][3:0] segColLo = {4'd2, 4'd0, 4'd0, 4'd2, 4'd12, 4'd12, 4'd2};
    localparam logic [6:0][3:0] segColHi = {4'd13, 4'd3, 4'd3, 4'd13, 4'd15, 4'd15, 4'd13};

    // Lit segments per digit, bit order gfedcba
    localparam logic [9:0][6:0] segmentTable = {
        7'h6F,  // 9
        7'h7F,  // 8
        7'h07,  // 7
        7'h7D,  // 6
        7'h6D,  // 5
        7'h66,  // 4
        7'h4F,  // 3
        7'h5B,  // 2
        7'h06,  // 1
        7'h3F   // 0
    };

    localparam logic [11:0] colorOn  = 12'hFFF;   // White foreground
    localparam logic [11:0] colorOff = 12'h000;

    ///////////////////////////////////////////////////////////////////////
    // Shared types
    ///////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       active;     // Inside the 640x480 area
        logic       vBlank;     // Lines 480 and up
    } pixelPos_t;

    typedef struct packed {
        logic [3:0] tens;
        logic [3:0] units;
    } digitPair_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] index;      // Field number, 0 is seconds
        digitPair_t digits;
    } fieldWrite_t;

    typedef digitPair_t [fieldCount-1:0] clockFace_t;

endpackage

/* source/videoTiming.sv */
`timescale 1ns/1ps

module videoTiming (
    input  logic                   clk,
    input  logic                   reset,
    output rtcDisplayPkg::pixelPos_t pos,
    output logic                   hsyncRaw,
    output logic                   vsyncRaw
);

    logic [9:0] hCount;     // Pixel within the line
    logic [9:0] vCount;     // Line within the frame
    logic       lineEnd;

    assign lineEnd = (hCount == 10'(rtcDisplayPkg::hTotal - 1));

    ///////////////////////////////////////////////////////////////////////
    // Pixel and line counters
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            hCount <= '0;
            vCount <= '0;
        end else begin
            if (lineEnd) begin
                hCount <= '0;
                // Frame wraps after the last back porch line
                if (vCount == 10'(rtcDisplayPkg::vTotal - 1))
                    vCount <= '0;
                else
                    vCount <= vCount + 10'd1;
            end else begin
                hCount <= hCount + 10'd1;
            end
        end
    end

    // Position bundle straight from the counters
    assign pos.x      = hCount;
    assign pos.y      = vCount;
    assign pos.active = (hCount < 10'(rtcDisplayPkg::hActive)) &&
                        (vCount < 10'(rtcDisplayPkg::vActive));
    assign pos.vBlank = (vCount >= 10'(rtcDisplayPkg::vActive));

    // Sync pulses, active low, not yet aligned with the renderer
    assign hsyncRaw = !((hCount >= 10'(rtcDisplayPkg::hActive + rtcDisplayPkg::hFront)) &&
                        (hCount <  10'(rtcDisplayPkg::hActive + rtcDisplayPkg::hFront +
                                       rtcDisplayPkg::hSync)));
    assign vsyncRaw = !((vCount >= 10'(rtcDisplayPkg::vActive + rtcDisplayPkg::vFront)) &&
                        (vCount <  10'(rtcDisplayPkg::vActive + rtcDisplayPkg::vFront +
                                       rtcDisplayPkg::vSync)));

    // Counters never leave the frame
    assert property (@(posedge clk) disable iff (reset)
        (hCount < 10'(rtcDisplayPkg::hTotal)) && (vCount < 10'(rtcDisplayPkg::vTotal)));

endmodule

/* source/fieldCapture.sv */
`timescale 1ns/1ps

module fieldCapture (
    input  logic                      clk,
    input  logic                      reset,
    input  rtcDisplayPkg::pixelPos_t  pos,
    input  logic                      dataValid,
    input  logic [7:0]                dataByte,
    output logic                      captureReady,
    output rtcDisplayPkg::fieldWrite_t fieldOut
);

    logic       vBlankQ;        // Previous blanking flag
    logic       windowStart;    // First cycle of a blanking window
    logic [2:0] fieldCnt;       // Fields accepted in this window
    logic       accept;
    logic [6:0] clamped;
    rtcDisplayPkg::digitPair_t split;

    assign windowStart = pos.vBlank && !vBlankQ;

    // Ready only inside blanking, and not while the counter is clearing
    assign captureReady = pos.vBlank && !windowStart &&
                          (fieldCnt < 3'(rtcDisplayPkg::fieldCount));
    assign accept = dataValid && captureReady;

    ///////////////////////////////////////////////////////////////////////
    // Clamp and decimal split
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        if (dataByte > 8'(rtcDisplayPkg::maxValue))
            clamped = 7'(rtcDisplayPkg::maxValue);  // Anything above 99 reads as 99
        else
            clamped = dataByte[6:0];
        split.tens  = 4'(clamped / 7'd10);
        split.units = 4'(clamped % 7'd10);
    end

    ///////////////////////////////////////////////////////////////////////
    // Window tracking and write register
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            vBlankQ  <= 1'b0;
            fieldCnt <= '0;
            fieldOut <= '0;
        end else begin
            vBlankQ <= pos.vBlank;
            if (windowStart)
                fieldCnt <= '0;                 // New window starts from seconds
            else if (accept)
                fieldCnt <= fieldCnt + 3'd1;

            fieldOut.valid <= accept;           // One cycle after the handshake
            if (accept) begin
                fieldOut.index  <= fieldCnt;
                fieldOut.digits <= split;
            end
        end
    end

    // Writes never point past the year field
    assert property (@(posedge clk) disable iff (reset)
        fieldOut.valid |-> (fieldOut.index <= 3'(rtcDisplayPkg::fieldCount - 1)));

endmodule

/* source/digitStore.sv */
`timescale 1ns/1ps

module digitStore (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       vBlank,
    input  rtcDisplayPkg::fieldWrite_t fieldIn,
    output rtcDisplayPkg::clockFace_t  face
);

    rtcDisplayPkg::clockFace_t shadow;                       // Written field by field
    logic [rtcDisplayPkg::fieldCount-1:0] writtenMask;       // Fields seen this window
    logic [rtcDisplayPkg::fieldCount-1:0] nextMask;
    logic vBlankQ;
    logic windowStart;
    logic commitPending;                                      // Shadow complete, copy next

    assign windowStart = vBlank && !vBlankQ;

    always_comb begin
        nextMask = writtenMask;
        if (fieldIn.valid)
            nextMask[fieldIn.index] = 1'b1;
    end

    ///////////////////////////////////////////////////////////////////////
    // Shadow bank, mask and all-or-nothing commit
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            vBlankQ       <= 1'b0;
            shadow        <= '0;
            writtenMask   <= '0;
            commitPending <= 1'b0;
            face          <= '0;
        end else begin
            vBlankQ <= vBlank;

            if (fieldIn.valid)
                shadow[fieldIn.index] <= fieldIn.digits;

            // A partial window stays in the mask until here, then is dropped
            if (windowStart)
                writtenMask <= '0;
            else
                writtenMask <= nextMask;

            commitPending <= fieldIn.valid && (&nextMask) && !windowStart;
            if (commitPending)
                face <= shadow;                 // Whole bank in one step
        end
    end

    // Display only moves right after the sixth field lands
    assert property (@(posedge clk) disable iff (reset)
        $changed(face) |-> $past($rose(&writtenMask)));

endmodule

/* source/segmentRenderer.sv */
`timescale 1ns/1ps

module segmentRenderer (
    input  logic                      clk,
    input  logic                      reset,
    input  rtcDisplayPkg::pixelPos_t  pos,
    input  logic                      hsyncRaw,
    input  logic                      vsyncRaw,
    input  rtcDisplayPkg::clockFace_t face,
    output logic [11:0]               rgb,
    output logic                      hsync,
    output logic                      vsync
);

    logic [9:0] relX;           // Pixel x from the text left edge
    logic [9:0] relY;
    logic       inRow;
    logic       inCell;         // On a digit cell, not a gap
    logic [3:0] cellDigit;
    logic [3:0] cellCol;

    // Stage 1 registers
    logic       drawQ;
    logic [3:0] digitQ;
    logic [4:0] rowQ;
    logic [3:0] colQ;
    logic       hsyncQ;
    logic       vsyncQ;

    logic [6:0] pattern;
    logic       segLit;

    ///////////////////////////////////////////////////////////////////////
    // Stage 1, cell lookup and digit select
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        relX      = pos.x - 10'(rtcDisplayPkg::textLeft);   // Wraps high left of text
        relY      = pos.y - 10'(rtcDisplayPkg::textTop);
        inRow     = (pos.y >= 10'(rtcDisplayPkg::textTop)) &&
                    (relY < 10'(rtcDisplayPkg::charHeight));
        inCell    = 1'b0;
        cellDigit = '0;
        cellCol   = '0;
        // Field f sits at slot f, seconds leftmost
        for (int f = 0; f < rtcDisplayPkg::fieldCount; f++) begin
            if ((relX >= 10'(f * rtcDisplayPkg::fieldPitch)) &&
                (relX <  10'(f * rtcDisplayPkg::fieldPitch + rtcDisplayPkg::charWidth))) begin
                inCell    = 1'b1;
                cellDigit = face[f].tens;
                cellCol   = 4'(relX - 10'(f * rtcDisplayPkg::fieldPitch));
            end else if ((relX >= 10'(f * rtcDisplayPkg::fieldPitch +
                                      rtcDisplayPkg::charWidth)) &&
                         (relX <  10'(f * rtcDisplayPkg::fieldPitch +
                                      2 * rtcDisplayPkg::charWidth))) begin
                inCell    = 1'b1;
                cellDigit = face[f].units;
                cellCol   = 4'(relX - 10'(f * rtcDisplayPkg::fieldPitch +
                                          rtcDisplayPkg::charWidth));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            drawQ  <= 1'b0;
            hsyncQ <= 1'b1;
            vsyncQ <= 1'b1;
        end else begin
            drawQ  <= pos.active && inRow && inCell;
            hsyncQ <= hsyncRaw;
            vsyncQ <= vsyncRaw;
        end
    end

    always_ff @(posedge clk) begin
        digitQ <= cellDigit;
        rowQ   <= relY[4:0];
        colQ   <= cellCol;
    end

    ///////////////////////////////////////////////////////////////////////
    // Stage 2, segment hit test and output register
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        pattern = (digitQ < 4'd10) ? rtcDisplayPkg::segmentTable[digitQ] : 7'h00;
        segLit  = 1'b0;
        for (int s = 0; s < 7; s++) begin
            if (pattern[s] &&
                (rowQ >= rtcDisplayPkg::segRowLo[s]) && (rowQ <= rtcDisplayPkg::segRowHi[s]) &&
                (colQ >= rtcDisplayPkg::segColLo[s]) && (colQ <= rtcDisplayPkg::segColHi[s]))
                segLit = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rgb   <= rtcDisplayPkg::colorOff;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= (drawQ && segLit) ? rtcDisplayPkg::colorOn : rtcDisplayPkg::colorOff;
            hsync <= hsyncQ;    // Two cycles behind the counters, same as rgb
            vsync <= vsyncQ;
        end
    end

endmodule

/* source/rtcDisplayTop.sv */
`timescale 1ns/1ps

module rtcDisplayTop (
    input  logic        clk,
    input  logic        reset,
    input  logic        dataValid,
    input  logic [7:0]  dataByte,
    output logic        captureReady,
    output logic [11:0] rgb,
    output logic        hsync,
    output logic        vsync
);

    rtcDisplayPkg::pixelPos_t   pos;
    rtcDisplayPkg::fieldWrite_t fieldWrite;
    rtcDisplayPkg::clockFace_t  face;
    logic hsyncRaw;
    logic vsyncRaw;

    ///////////////////////////////////////////////////////////////////////
    // Timing, capture, storage, drawing
    ///////////////////////////////////////////////////////////////////////
    videoTiming i_timing (
        .clk      (clk),
        .reset    (reset),
        .pos      (pos),
        .hsyncRaw (hsyncRaw),
        .vsyncRaw (vsyncRaw)
    );

    fieldCapture i_capture (
        .clk          (clk),
        .reset        (reset),
        .pos          (pos),
        .dataValid    (dataValid),
        .dataByte     (dataByte),
        .captureReady (captureReady),
        .fieldOut     (fieldWrite)
    );

    digitStore i_store (
        .clk     (clk),
        .reset   (reset),
        .vBlank  (pos.vBlank),      // Window open flag
        .fieldIn (fieldWrite),
        .face    (face)
    );

    segmentRenderer i_render (
        .clk      (clk),
        .reset    (reset),
        .pos      (pos),
        .hsyncRaw (hsyncRaw),
        .vsyncRaw (vsyncRaw),
        .face     (face),
        .rgb      (rgb),
        .hsync    (hsync),
        .vsync    (vsync)
    );

endmodule

/* tb/rtcDisplayChecker.sv */
`timescale 1ns/1ps

module rtcDisplayChecker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [11:0]               rgb,
    input  logic                      hsync,
    input  logic                      vsync,
    input  logic                      captureReady,
    input  rtcDisplayPkg::clockFace_t modelFace,    // Face the model expects on screen
    output logic                      done,
    output int                        checkCount,
    output int                        errorCount
);

    localparam int resetTest = 0;
    localparam int syncTest  = 1;
    localparam int blankTest = 2;
    localparam int readyTest = 3;
    localparam int faceTest  = 4;

    // Probe points, centre of each segment rectangle, index 0 is segment a
    localparam logic [6:0][4:0] probeRow = {5'd15, 5'd8, 5'd22, 5'd29, 5'd22, 5'd8, 5'd1};
    localparam logic [6:0][3:0] probeCol = {4'd7, 4'd1, 4'd1, 4'd7, 4'd13, 4'd13, 4'd7};
    // Standard seven-segment digits, bit order gfedcba, digit 9 first
    localparam logic [9:0][6:0] litMask = {7'h6F, 7'h7F, 7'h07, 7'h7D, 7'h6D,
                                           7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F};

    int   edges;            // Rising edges since reset released
    logic inReset;          // Reset as seen by the last rising edge
    int   testErrors [5];

    initial begin
        done       = 1'b0;
        checkCount = 0;
        errorCount = 0;
        for (int t = 0; t < 5; t++)
            testErrors[t] = 0;
    end

    task automatic compare(input int test, input string name,
                           input logic [11:0] expected, input logic [11:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            testErrors[test]++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic string frameName(input int f);
        case (f)
            0: return "zeroFace";
            1: return "fullWindow";
            2: return "clampTo99";
            3: return "partialWindow";
            4: return "randomFace";
            default: return "finalFace";
        endcase
    endfunction

    function automatic string faceText();
        string t;
        t = "";
        for (int i = 0; i < 6; i++)
            t = {t, $sformatf(" %0d%0d", modelFace[i].tens, modelFace[i].units)};
        return t;
    endfunction

    always @(posedge clk) begin
        inReset <= reset;
        edges   <= reset ? 0 : edges + 1;
    end

    ////////////////////////////////////////////////////////////////////////
    // Per-cycle checks, outputs are stable at the falling edge
    ////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin : sample
        int q;
        int oh;
        int ov;
        int f;
        int relX;
        int d;
        int digit;
        if (inReset === 1'b1) begin
            compare(resetTest, "reset rgb", 12'h000, rgb);
            compare(resetTest, "reset hsync", 12'h001, 12'(hsync));
            compare(resetTest, "reset vsync", 12'h001, 12'(vsync));
            compare(resetTest, "reset captureReady", 12'h000, 12'(captureReady));
        end else if (inReset === 1'b0 && !done) begin
            if (edges == 1)
                $display("reset: %0d errors", testErrors[resetTest]);
            // Counters sit at pixel number edges, active lines block the handshake
            if (((edges / 800) % 525) < 480)
                compare(readyTest, "captureReady in active line", 12'h000, 12'(captureReady));
            if (edges >= 2) begin
                q  = edges - 2;             // Pixel now on the outputs
                oh = q % 800;
                ov = (q / 800) % 525;
                f  = q / 420000;
                compare(syncTest, "hsync", 12'(!(oh >= 656 && oh < 752)), 12'(hsync));
                compare(syncTest, "vsync", 12'(!(ov >= 490 && ov < 492)), 12'(vsync));
                if (oh >= 640 || ov >= 480)
                    compare(blankTest, "rgb outside active area", 12'h000, rgb);
                relX = oh - 176;
                if (ov >= 224 && ov < 256 && relX >= 0 && relX < 288 && relX % 48 < 32) begin
                    d     = (relX / 48) * 2 + (relX % 48) / 16;    // Even is tens
                    digit = (d % 2 == 0) ? modelFace[d / 2].tens : modelFace[d / 2].units;
                    for (int s = 0; s < 7; s++) begin
                        if (ov - 224 == probeRow[s] && relX % 16 == probeCol[s])
                            compare(faceTest,
                                    $sformatf("%s digit %0d seg %0d", frameName(f), d, s),
                                    litMask[digit][s] ? 12'hFFF : 12'h000, rgb);
                    end
                end
                if (oh == 0 && ov == 480) begin     // Active rows of frame f are over
                    $display("%s: face%s, %0d errors", frameName(f), faceText(),
                             testErrors[faceTest]);
                    testErrors[faceTest] = 0;
                    if (f == 5) begin
                        $display("sync: %0d errors", testErrors[syncTest]);
                        $display("blanking rgb: %0d errors", testErrors[blankTest]);
                        $display("captureReady: %0d errors", testErrors[readyTest]);
                        done = 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* tb/rtcDisplayTb.sv */
`timescale 1ns/1ps

module rtcDisplayTb;

    // Six frames of 800 x 525 pixels plus margin
    localparam int timeoutCycles = 6 * 420000 + 10000;

    logic        clk;
    logic        reset;
    logic        dataValid;
    logic [7:0]  dataByte;
    logic        captureReady;
    logic [11:0] rgb;
    logic        hsync;
    logic        vsync;
    logic        done;
    int          checkCount;
    int          errorCount;
    int          cycleCount = 0;
    rtcDisplayPkg::clockFace_t modelFace;   // Last fully written face

    rtcDisplayTop i_dut (
        .clk          (clk),
        .reset        (reset),
        .dataValid    (dataValid),
        .dataByte     (dataByte),
        .captureReady (captureReady),
        .rgb          (rgb),
        .hsync        (hsync),
        .vsync        (vsync)
    );

    rtcDisplayChecker i_checker (
        .clk          (clk),
        .reset        (reset),
        .rgb          (rgb),
        .hsync        (hsync),
        .vsync        (vsync),
        .captureReady (captureReady),
        .modelFace    (modelFace),
        .done         (done),
        .checkCount   (checkCount),
        .errorCount   (errorCount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    ////////////////////////////////////////////////////////////////////////
    // Source side of the handshake
    ////////////////////////////////////////////////////////////////////////
    // Returns on the falling edge after the accepting rising edge
    task automatic sendByte(input logic [7:0] value);
        dataValid = 1'b1;
        dataByte  = value;
        while (!captureReady)
            @(negedge clk);
        @(negedge clk);
    endtask

    // Mode 0 is below 100, mode 1 is 100 and up, mode 2 is anything to 127
    task automatic runWindow(input int count, input int mode);
        rtcDisplayPkg::clockFace_t pending;
        logic [7:0] value;
        int shown;
        int gap;
        pending = modelFace;
        for (int i = 0; i < count; i++) begin
            gap = (i > 0) ? $urandom_range(0, 3) : 0;
            if (gap > 0) begin
                dataValid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            case (mode)
                0: value = 8'($urandom_range(0, 99));
                1: value = 8'($urandom_range(100, 127));
                default: value = 8'($urandom_range(0, 127));
            endcase
            sendByte(value);
            shown = (value > 99) ? 99 : value;      // Clamp to 99 then split into digits
            pending[i].tens  = 4'(shown / 10);
            pending[i].units = 4'(shown % 10);
        end
        if (count == 6) begin
            modelFace = pending;
        end else begin
            dataValid = 1'b0;                       // Let the window run out
            while (captureReady)
                @(negedge clk);
        end
    endtask

    initial begin : stimulus
        reset     = 1'b1;
        dataValid = 1'b0;
        dataByte  = 8'h00;
        modelFace = '0;
        void'($urandom(78));
        repeat (5) @(negedge clk);
        reset = 1'b0;
        runWindow(6, 0);    // Seconds byte waits out the first active area
        runWindow(6, 1);    // Every field reads 99
        runWindow(4, 2);    // Incomplete window
        runWindow(6, 2);
        runWindow(6, 2);
        dataValid = 1'b0;
    end

    initial begin : runControl
        @(negedge clk);
        while (!done && cycleCount < timeoutCycles)
            @(negedge clk);
        if (!done) begin
            $display("Timeout after %0d cycles, the last frame was never checked", cycleCount);
            $display("=== FAIL ===");
        end else begin
            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            if (errorCount == 0)
                $display("=== PASS ===");
            else
                $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* filelist.f */
source/rtcDisplayPkg.sv
source/videoTiming.sv
source/fieldCapture.sv
source/digitStore.sv
source/segmentRenderer.sv
source/rtcDisplayTop.sv
tb/rtcDisplayChecker.sv
tb/rtcDisplayTb.sv
